//--- build.f
hdl/mem_bus_pkg.sv
hdl/read_req_pkg.sv
hdl/arid_free_list.sv
hdl/read_miss_table.sv
hdl/line_request_splitter.sv
hdl/rdata_fifo.sv
hdl/line_word_unpacker.sv
hdl/ro_read_engine.sv
tests/axi_read_slave.sv
tests/tb_ro_read_engine.sv

//--- tests/tb_ro_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ro_read_engine;

   import mem_bus_pkg::*;
   import read_req_pkg::*;

   localparam int    ID_BITS        = 5;
   localparam int    FIFO_LOG_DEPTH = 2;
   localparam int    REQ_TIMEOUT    = 3000;   // cycles
   localparam int    DRAIN_TIMEOUT  = 6000;
   localparam word_t DATA_KEY       = 32'h5a5a5a5a;

   logic               clk;
   logic               rstn;
   logic               req_valid;
   logic               req_ready;
   addr_t              req_addr;
   word_count_t        req_words;
   tag_t               req_tag;
   logic               arvalid;
   logic               arready;
   addr_t              araddr;
   logic [ID_BITS-1:0] arid;
   logic               rvalid;
   logic               rready;
   logic [ID_BITS-1:0] rid;
   line_t              rdata;
   logic               out_valid;
   logic               out_ready;
   word_t              out_word;
   tag_t               out_tag;
   word_count_t        out_word_id;
   logic               out_line_last;
   logic               idle;

   // expected words in request order
   tag_t        exp_tag_q  [$];
   word_count_t exp_id_q   [$];
   word_t       exp_data_q [$];
   logic        exp_last_q [$];
   addr_t       ar_log     [$];

   string       test_name;
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;
   int          ready_mode;   // 0 always ready, 1 random, 2 held low
   logic        held;
   word_t       held_word;
   tag_t        held_tag;
   word_count_t held_id;
   logic        held_last;

   ro_read_engine #(
      .ID_BITS        (ID_BITS),
      .FIFO_LOG_DEPTH (FIFO_LOG_DEPTH)
   ) dut (
      .clk           (clk),
      .rstn          (rstn),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .req_addr      (req_addr),
      .req_words     (req_words),
      .req_tag       (req_tag),
      .arvalid       (arvalid),
      .arready       (arready),
      .araddr        (araddr),
      .arid          (arid),
      .rvalid        (rvalid),
      .rready        (rready),
      .rid           (rid),
      .rdata         (rdata),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_word      (out_word),
      .out_tag       (out_tag),
      .out_word_id   (out_word_id),
      .out_line_last (out_line_last),
      .idle          (idle)
   );

   axi_read_slave #(
      .ID_BITS(ID_BITS)
   ) mem (
      .clk     (clk),
      .rstn    (rstn),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .arid    (arid),
      .rvalid  (rvalid),
      .rready  (rready),
      .rid     (rid),
      .rdata   (rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic note_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected === actual) else begin
         $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
         note_error();
      end
   endtask

   task automatic check_output_word();
      assert (exp_data_q.size() != 0) else begin
         $display("%s: output word %h arrived with no word expected", test_name, out_word);
         note_error();
      end
      if (exp_data_q.size() != 0) begin
         check_value("tag", exp_tag_q.pop_front(), out_tag);
         check_value("word id", exp_id_q.pop_front(), out_word_id);
         check_value("data", exp_data_q.pop_front(), out_word);
         check_value("line last", exp_last_q.pop_front(), out_line_last);
      end
   endtask

   // output monitor, beat log and the hold-steady check
   always @(posedge clk) begin
      if (!rstn) begin
         held = 1'b0;
      end else begin
         if (arvalid && arready) begin
            ar_log.push_back(araddr);
         end
         if (held) begin
            check_value("held out_valid", 1, out_valid);
            check_value("held word", held_word, out_word);
            check_value("held tag", held_tag, out_tag);
            check_value("held word id", held_id, out_word_id);
            check_value("held line last", held_last, out_line_last);
         end
         if (out_valid && out_ready) begin
            check_output_word();
         end
         held      = out_valid && !out_ready;
         held_word = out_word;
         held_tag  = out_tag;
         held_id   = out_word_id;
         held_last = out_line_last;
      end
   end

   always @(posedge clk) begin
      case (ready_mode)
         0:       out_ready <= 1'b1;
         1:       out_ready <= 1'($urandom_range(1));
         default: out_ready <= 1'b0;
      endcase
   end

   task automatic expect_request(input addr_t addr, input word_count_t words, input tag_t tag);
      addr_t a;
      for (int i = 0; i < int'(words); i++) begin
         a = addr + addr_t'(4 * i);
         exp_tag_q.push_back(tag);
         exp_id_q.push_back(word_count_t'(i));
         exp_data_q.push_back(a ^ DATA_KEY);
         // a line ends at its top word or where the run ends
         exp_last_q.push_back((a[5:2] == 4'hf) || (i == int'(words) - 1));
      end
   endtask

   task automatic send_request(input addr_t addr, input word_count_t words, input tag_t tag);
      int waited;
      waited = 0;
      expect_request(addr, words, tag);
      req_valid <= 1'b1;
      req_addr  <= addr;
      req_words <= words;
      req_tag   <= tag;
      @(posedge clk);
      while (!req_ready && waited < REQ_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      assert (req_ready) else begin
         $display("%s: timeout, request at %h was never taken", test_name, addr);
         note_error();
      end
      req_valid <= 1'b0;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while ((exp_data_q.size() != 0 || !idle) && waited < DRAIN_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      assert (exp_data_q.size() == 0 && idle) else begin
         $display("%s: timeout with %0d words still missing, idle %b",
                  test_name, exp_data_q.size(), idle);
         note_error();
         exp_tag_q.delete();
         exp_id_q.delete();
         exp_data_q.delete();
         exp_last_q.delete();
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
      ar_log.delete();
   endtask

   task automatic end_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic apply_reset();
      start_test("reset");
      rstn = 1'b0;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      check_value("req_ready", 1, req_ready);
      check_value("arvalid", 0, arvalid);
      check_value("out_valid", 0, out_valid);
      check_value("idle", 1, idle);
      end_test();
   endtask

   task automatic test_single_word();
      start_test("single_word");
      send_request(32'h0000_101c, 8'd1, 4'h5);   // word 7 of its line
      wait_drained();
      check_value("beat count", 1, ar_log.size());
      if (ar_log.size() > 0) begin
         check_value("beat 0 address", 32'h0000_101c, ar_log[0]);
      end
      end_test();
   endtask

   task automatic test_line_crossing();
      start_test("line_crossing");
      send_request(32'h0000_2028, 8'd26, 4'h2);  // word 10, runs into a third line
      wait_drained();
      check_value("beat count", 3, ar_log.size());
      if (ar_log.size() == 3) begin
         check_value("beat 0 address", 32'h0000_2028, ar_log[0]);
         check_value("beat 1 address", 32'h0000_2040, ar_log[1]);
         check_value("beat 2 address", 32'h0000_2080, ar_log[2]);
      end
      end_test();
   endtask

   task automatic test_back_to_back();
      start_test("back_to_back");
      send_request(32'h0000_3010, 8'd5, 4'h3);
      send_request(32'h0000_3100, 8'd18, 4'h7);
      send_request(32'h0000_33f8, 8'd3, 4'hc);
      wait_drained();
      end_test();
   endtask

   task automatic test_out_backpressure();
      start_test("out_backpressure");
      ready_mode <= 1;
      send_request(32'h0000_4004, 8'd40, 4'h1);
      send_request(32'h0000_5030, 8'd17, 4'he);
      wait_drained();
      ready_mode <= 0;
      @(posedge clk);
      end_test();
   endtask

   task automatic test_id_reuse();
      start_test("id_reuse");
      // 40 lines in all, more than the 32 read ids
      ready_mode <= 2;
      send_request(32'h0001_0000, 8'd255, 4'h9);   // 16 lines
      send_request(32'h0002_0004, 8'd255, 4'ha);   // 16 lines
      send_request(32'h0003_0000, 8'd128, 4'hb);   // 8 lines that wait for free ids
      repeat (80) @(posedge clk);
      // only the line held by the unpacker has given its id back
      check_value("beats with no free id", (1 << ID_BITS) + 1, ar_log.size());
      ready_mode <= 0;
      wait_drained();
      check_value("beat count", 40, ar_log.size());
      end_test();
   endtask

   initial begin
      void'($urandom(32'h4bc4));
      rstn         = 1'b0;
      req_valid    = 1'b0;
      req_addr     = '0;
      req_words    = '0;
      req_tag      = '0;
      out_ready    = 1'b0;
      ready_mode   = 0;
      held         = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;

      apply_reset();
      test_single_word();
      test_line_crossing();
      test_back_to_back();
      test_out_backpressure();
      test_id_reuse();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/axi_read_slave.sv
`timescale 1ns/1ps
`default_nettype none

// in-order memory model, one 64-byte line back per address beat
module axi_read_slave #(
   parameter int ID_BITS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               arvalid,
   output logic               arready,
   input  mem_bus_pkg::addr_t araddr,
   input  logic [ID_BITS-1:0] arid,

   output logic               rvalid,
   input  logic               rready,
   output logic [ID_BITS-1:0] rid,
   output mem_bus_pkg::line_t rdata
);

   import mem_bus_pkg::*;

   addr_t              addr_q [$];   // beats taken, not yet answered
   logic [ID_BITS-1:0] id_q   [$];
   logic               sending;
   int                 gap;          // cycles before the next line goes out

   // word w of the line at base b holds (b + 4w) xor 5a5a5a5a
   function automatic line_t make_line(input addr_t addr);
      line_t l;
      addr_t base;
      base = addr & ~addr_t'(LINE_WORDS * 4 - 1);
      for (int w = 0; w < LINE_WORDS; w++) begin
         l[w*WORD_BITS +: WORD_BITS] = (base + addr_t'(4 * w)) ^ 32'h5a5a5a5a;
      end
      return l;
   endfunction

   initial begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rid     = '0;
      rdata   = '0;
      sending = 1'b0;
      gap     = 0;
   end

   always @(posedge clk) begin
      if (!rstn) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         sending = 1'b0;
         gap     = 0;
         addr_q.delete();
         id_q.delete();
      end else begin
         if (arvalid && arready) begin
            addr_q.push_back(araddr);
            id_q.push_back(arid);
         end
         arready <= ($urandom_range(3) != 0);   // low about one cycle in four
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            sending = 1'b0;
         end
         if (!sending && addr_q.size() != 0) begin
            if (gap == 0) begin
               rid     <= id_q.pop_front();
               rdata   <= make_line(addr_q.pop_front());
               rvalid  <= 1'b1;
               sending = 1'b1;
               gap     = $urandom_range(3);
            end else begin
               gap = gap - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/ro_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module ro_read_engine #(
   parameter int ID_BITS        = 5,
   parameter int FIFO_LOG_DEPTH = 2
) (
   input  logic                      clk,
   input  logic                      rstn,

   input  logic                      req_valid,
   output logic                      req_ready,
   input  mem_bus_pkg::addr_t        req_addr,
   input  read_req_pkg::word_count_t req_words,
   input  read_req_pkg::tag_t        req_tag,

   output logic                      arvalid,
   input  logic                      arready,
   output mem_bus_pkg::addr_t        araddr,
   output logic [ID_BITS-1:0]        arid,

   input  logic                      rvalid,
   output logic                      rready,
   input  logic [ID_BITS-1:0]        rid,
   input  mem_bus_pkg::line_t        rdata,

   output logic                      out_valid,
   input  logic                      out_ready,
   output mem_bus_pkg::word_t        out_word,
   output read_req_pkg::tag_t        out_tag,
   output read_req_pkg::word_count_t out_word_id,
   output logic                      out_line_last,

   output logic                      idle
);

   import mem_bus_pkg::*;
   import read_req_pkg::*;

   logic               id_alloc;
   logic [ID_BITS-1:0] alloc_id;
   logic               id_empty;
   logic               id_release;
   logic [ID_BITS-1:0] release_id;

   logic               mt_wr_en;
   word_mask_t         mt_wr_mask;
   tag_t               mt_wr_tag;
   word_count_t        mt_wr_start;
   logic [ID_BITS-1:0] mt_rd_id;
   word_mask_t         mt_rd_mask;
   tag_t               mt_rd_tag;
   word_count_t        mt_rd_start;

   logic               fifo_full;
   logic               fifo_empty;
   logic               fifo_pop;
   logic [ID_BITS-1:0] fifo_id;
   line_t              fifo_line;

   assign rready = !fifo_full;

   arid_free_list #(
      .ID_BITS(ID_BITS)
   ) u_free_list (
      .clk        (clk),
      .rstn       (rstn),
      .alloc      (id_alloc),
      .alloc_id   (alloc_id),
      .empty      (id_empty),
      .release_en (id_release),
      .release_id (release_id),
      .all_free   (idle)
   );

   read_miss_table #(
      .ID_BITS(ID_BITS)
   ) u_miss_table (
      .clk      (clk),
      .wr_en    (mt_wr_en),
      .wr_id    (alloc_id),     // same id that goes out on arid
      .wr_mask  (mt_wr_mask),
      .wr_tag   (mt_wr_tag),
      .wr_start (mt_wr_start),
      .rd_id    (mt_rd_id),
      .rd_mask  (mt_rd_mask),
      .rd_tag   (mt_rd_tag),
      .rd_start (mt_rd_start)
   );

   line_request_splitter #(
      .ID_BITS(ID_BITS)
   ) u_splitter (
      .clk       (clk),
      .rstn      (rstn),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_words (req_words),
      .req_tag   (req_tag),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .arid      (arid),
      .id_alloc  (id_alloc),
      .id_free   (alloc_id),
      .id_empty  (id_empty),
      .mt_wr_en  (mt_wr_en),
      .mt_mask   (mt_wr_mask),
      .mt_tag    (mt_wr_tag),
      .mt_start  (mt_wr_start)
   );

   rdata_fifo #(
      .ID_BITS        (ID_BITS),
      .FIFO_LOG_DEPTH (FIFO_LOG_DEPTH)
   ) u_rdata_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (rvalid && rready),
      .wr_id   (rid),
      .wr_line (rdata),
      .full    (fifo_full),
      .rd_en   (fifo_pop),
      .rd_id   (fifo_id),
      .rd_line (fifo_line),
      .empty   (fifo_empty)
   );

   line_word_unpacker #(
      .ID_BITS(ID_BITS)
   ) u_unpacker (
      .clk           (clk),
      .rstn          (rstn),
      .fifo_empty    (fifo_empty),
      .fifo_pop      (fifo_pop),
      .line          (fifo_line),
      .rid           (fifo_id),
      .mt_id         (mt_rd_id),
      .mask          (mt_rd_mask),
      .tag           (mt_rd_tag),
      .start         (mt_rd_start),
      .id_release    (id_release),
      .release_id    (release_id),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_word      (out_word),
      .out_tag       (out_tag),
      .out_word_id   (out_word_id),
      .out_line_last (out_line_last)
   );

endmodule

`default_nettype wire

//--- hdl/line_word_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module line_word_unpacker #(
   parameter int ID_BITS = 5
) (
   input  logic                      clk,
   input  logic                      rstn,

   input  logic                      fifo_empty,
   output logic                      fifo_pop,
   input  mem_bus_pkg::line_t        line,
   input  logic [ID_BITS-1:0]        rid,

   output logic [ID_BITS-1:0]        mt_id,
   input  read_req_pkg::word_mask_t  mask,
   input  read_req_pkg::tag_t        tag,
   input  read_req_pkg::word_count_t start,

   output logic                      id_release,
   output logic [ID_BITS-1:0]        release_id,

   output logic                      out_valid,
   input  logic                      out_ready,
   output mem_bus_pkg::word_t        out_word,
   output read_req_pkg::tag_t        out_tag,
   output read_req_pkg::word_count_t out_word_id,
   output logic                      out_line_last
);

   import mem_bus_pkg::*;
   import read_req_pkg::*;

   logic           busy;        // a line is being emitted
   line_t          cur_line;
   word_mask_t     cur_mask;    // words not yet sent
   tag_t           cur_tag;
   word_count_t    word_id;
   line_word_idx_t sel;
   logic           out_fire;

   // lowest wanted word goes first
   always_comb begin
      sel = '0;
      for (int i = LINE_WORDS - 1; i >= 0; i--) begin
         if (cur_mask[i]) begin
            sel = line_word_idx_t'(i);
         end
      end
   end

   assign out_valid     = busy;
   assign out_word      = cur_line[sel*WORD_BITS +: WORD_BITS];
   assign out_tag       = cur_tag;
   assign out_word_id   = word_id;
   assign out_line_last = ((cur_mask & (cur_mask - 1'b1)) == '0);   // single bit left
   assign out_fire      = out_valid && out_ready;

   // next line comes in as the last word of this one leaves
   assign fifo_pop = !fifo_empty && (!busy || (out_fire && out_line_last));

   // the id is done once its entry has been read out of the table
   assign mt_id      = rid;
   assign id_release = fifo_pop;
   assign release_id = rid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (fifo_pop) begin
         busy <= 1'b1;
      end else if (out_fire && out_line_last) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         cur_line <= line;
         cur_mask <= mask;
         cur_tag  <= tag;
         word_id  <= start;
      end else if (out_fire) begin
         cur_mask[sel] <= 1'b0;
         word_id       <= word_id + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hdl/rdata_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rdata_fifo #(
   parameter int ID_BITS        = 5,
   parameter int FIFO_LOG_DEPTH = 2
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               wr_en,
   input  logic [ID_BITS-1:0] wr_id,
   input  mem_bus_pkg::line_t wr_line,
   output logic               full,

   input  logic               rd_en,
   output logic [ID_BITS-1:0] rd_id,
   output mem_bus_pkg::line_t rd_line,
   output logic               empty
);

   import mem_bus_pkg::*;

   logic [ID_BITS-1:0] id_mem   [2**FIFO_LOG_DEPTH];
   line_t              line_mem [2**FIFO_LOG_DEPTH];

   // one extra bit to tell full from empty
   logic [FIFO_LOG_DEPTH:0] wr_ptr;
   logic [FIFO_LOG_DEPTH:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         id_mem[wr_ptr[FIFO_LOG_DEPTH-1:0]]   <= wr_id;
         line_mem[wr_ptr[FIFO_LOG_DEPTH-1:0]] <= wr_line;
      end
   end

   assign rd_id   = id_mem[rd_ptr[FIFO_LOG_DEPTH-1:0]];
   assign rd_line = line_mem[rd_ptr[FIFO_LOG_DEPTH-1:0]];

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[FIFO_LOG_DEPTH] != rd_ptr[FIFO_LOG_DEPTH])
                  && (wr_ptr[FIFO_LOG_DEPTH-1:0] == rd_ptr[FIFO_LOG_DEPTH-1:0]);

endmodule

`default_nettype wire

//--- hdl/line_request_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module line_request_splitter #(
   parameter int ID_BITS = 5
) (
   input  logic                      clk,
   input  logic                      rstn,

   input  logic                      req_valid,
   output logic                      req_ready,
   input  mem_bus_pkg::addr_t        req_addr,
   input  read_req_pkg::word_count_t req_words,
   input  read_req_pkg::tag_t        req_tag,

   output logic                      arvalid,
   input  logic                      arready,
   output mem_bus_pkg::addr_t        araddr,
   output logic [ID_BITS-1:0]        arid,

   output logic                      id_alloc,
   input  logic [ID_BITS-1:0]        id_free,
   input  logic                      id_empty,

   output logic                      mt_wr_en,
   output read_req_pkg::word_mask_t  mt_mask,
   output read_req_pkg::tag_t        mt_tag,
   output read_req_pkg::word_count_t mt_start
);

   import mem_bus_pkg::*;
   import read_req_pkg::*;

   localparam int LINE_BYTES = LINE_BITS / 8;
   localparam int LINE_OFS_BITS = $clog2(LINE_BYTES);

   split_state_t   state;
   addr_t          cur_addr;
   word_count_t    words_left;
   word_count_t    next_start;
   tag_t           cur_tag;

   logic           req_fire;
   logic           ar_fire;
   line_word_idx_t word_ofs;
   word_count_t    first_word;
   word_count_t    room;         // words from the offset to the end of the line
   word_count_t    beat_words;
   word_count_t    end_word;
   logic           last_beat;
   word_mask_t     beat_mask;
   addr_t          next_line_addr;

   assign req_ready = (state == split_idle);
   assign req_fire  = req_valid && req_ready;

   // a beat only goes out with an id in hand
   assign arvalid = (state == split_issue) && !id_empty;
   assign ar_fire = arvalid && arready;

   assign word_ofs   = cur_addr[LINE_OFS_BITS-1:2];
   assign first_word = word_count_t'(word_ofs);
   assign room       = word_count_t'(LINE_WORDS) - first_word;
   assign last_beat  = (words_left <= room);
   assign beat_words = last_beat ? words_left : room;
   assign end_word   = first_word + beat_words;

   always_comb begin
      for (int i = 0; i < LINE_WORDS; i++) begin
         beat_mask[i] = (word_count_t'(i) >= first_word) && (word_count_t'(i) < end_word);
      end
   end

   assign next_line_addr = (cur_addr | addr_t'(LINE_BYTES - 1)) + addr_t'(1);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= split_idle;
      end else begin
         case (state)
            split_idle: begin
               if (req_fire) begin
                  state <= split_issue;
               end
            end
            split_issue: begin
               if (ar_fire && last_beat) begin
                  state <= split_idle;
               end
            end
            default: state <= split_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_fire) begin
         cur_addr   <= req_addr;
         words_left <= req_words;
         next_start <= '0;
         cur_tag    <= req_tag;
      end else if (ar_fire && !last_beat) begin
         cur_addr   <= next_line_addr;   // later beats are line aligned
         words_left <= words_left - beat_words;
         next_start <= next_start + beat_words;
      end
   end

   assign araddr   = cur_addr;
   assign arid     = id_free;
   assign id_alloc = ar_fire;

   assign mt_wr_en = ar_fire;
   assign mt_mask  = beat_mask;
   assign mt_tag   = cur_tag;
   assign mt_start = next_start;

endmodule

`default_nettype wire

//--- hdl/read_miss_table.sv
`timescale 1ns/1ps
`default_nettype none

module read_miss_table #(
   parameter int ID_BITS = 5
) (
   input  logic                      clk,

   input  logic                      wr_en,
   input  logic [ID_BITS-1:0]        wr_id,
   input  read_req_pkg::word_mask_t  wr_mask,
   input  read_req_pkg::tag_t        wr_tag,
   input  read_req_pkg::word_count_t wr_start,

   input  logic [ID_BITS-1:0]        rd_id,
   output read_req_pkg::word_mask_t  rd_mask,
   output read_req_pkg::tag_t        rd_tag,
   output read_req_pkg::word_count_t rd_start
);

   import read_req_pkg::*;

   word_mask_t  mask_mem  [2**ID_BITS];   // wanted words of the line
   tag_t        tag_mem   [2**ID_BITS];
   word_count_t start_mem [2**ID_BITS];   // request position of the first wanted word

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mask_mem[wr_id]  <= wr_mask;
         tag_mem[wr_id]   <= wr_tag;
         start_mem[wr_id] <= wr_start;
      end
   end

   assign rd_mask  = mask_mem[rd_id];
   assign rd_tag   = tag_mem[rd_id];
   assign rd_start = start_mem[rd_id];

endmodule

`default_nettype wire

//--- hdl/arid_free_list.sv
`timescale 1ns/1ps
`default_nettype none

module arid_free_list #(
   parameter int ID_BITS = 5
) (
   input  logic               clk,
   input  logic               rstn,

   input  logic               alloc,
   output logic [ID_BITS-1:0] alloc_id,
   output logic               empty,

   input  logic               release_en,
   input  logic [ID_BITS-1:0] release_id,

   output logic               all_free
);

   localparam logic [ID_BITS:0] N_IDS = 2**ID_BITS;

   logic [ID_BITS-1:0] ring [2**ID_BITS];
   logic [ID_BITS-1:0] head;
   logic [ID_BITS-1:0] tail;
   logic [ID_BITS:0]   count;   // ids currently in the ring

   always_ff @(posedge clk) begin
      if (!rstn) begin
         // every id starts out free, in order
         for (int i = 0; i < 2**ID_BITS; i++) begin
            ring[i] <= ID_BITS'(i);
         end
         head  <= '0;
         tail  <= '0;
         count <= N_IDS;
      end else begin
         if (alloc) begin
            head <= head + 1'b1;
         end
         if (release_en) begin
            ring[tail] <= release_id;
            tail       <= tail + 1'b1;
         end
         if (alloc && !release_en) begin
            count <= count - 1'b1;
         end else if (release_en && !alloc) begin
            count <= count + 1'b1;
         end
      end
   end

   assign alloc_id = ring[head];
   assign empty    = (count == '0);
   assign all_free = (count == N_IDS);

endmodule

`default_nettype wire

//--- hdl/read_req_pkg.sv
`default_nettype none

// request side types shared by the splitter, miss table and unpacker
package read_req_pkg;

   localparam int TAG_BITS        = 4;
   localparam int WORD_COUNT_BITS = 8;

   typedef logic [TAG_BITS-1:0]        tag_t;
   typedef logic [WORD_COUNT_BITS-1:0] word_count_t;   // run length or word position

   // one bit per word of a cache line
   typedef logic [mem_bus_pkg::LINE_WORDS-1:0] word_mask_t;

   typedef enum logic {
      split_idle,
      split_issue
   } split_state_t;

endpackage

`default_nettype wire

//--- hdl/mem_bus_pkg.sv
`default_nettype none

// widths of the memory read bus and the cache line layout
package mem_bus_pkg;

   localparam int ADDR_BITS  = 32;
   localparam int WORD_BITS  = 32;
   localparam int LINE_WORDS = 16;
   localparam int LINE_BITS  = LINE_WORDS * WORD_BITS;   // 512, one 64-byte line

   typedef logic [ADDR_BITS-1:0] addr_t;                  // byte address
   typedef logic [WORD_BITS-1:0] word_t;
   typedef logic [LINE_BITS-1:0] line_t;

   // word slot inside a line
   typedef logic [$clog2(LINE_WORDS)-1:0] line_word_idx_t;

endpackage

`default_nettype wire
